// File: compile.f
+incdir+dv
hw/i8085_pkg.sv
hw/alu.sv
hw/bus_sequencer.sv
hw/instr_decode.sv
hw/reg_file.sv
hw/cpu_top.sv
dv/tb_cpu.sv

// File: dv/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int PROG_UNITS = 200; // random units before the final hlt

byte_t mem [0:65535]; // bus side image, takes the dut writes
byte_t model_mem [0:65535];
byte_t m_reg [0:7]; // b c d e h l - a
byte_t m_flags;
cycle_e exp_kind [$];
addr_t exp_addr [$];
byte_t exp_data [$];

function automatic byte_t rand_byte();
	int unsigned v;
	v = $urandom;
	return v[7:0];
endfunction

function automatic logic [2:0] rand3();
	int unsigned v;
	v = $urandom % 8;
	return v[2:0];
endfunction

// any register except m
function automatic logic [2:0] pick_reg();
	int unsigned v;
	v = $urandom % 7;
	return (v == 6) ? REG_A : v[2:0];
endfunction

task automatic emit(inout addr_t pc, input byte_t b);
	mem[pc] = b;
	pc = pc + 16'd1;
endtask

// mvi h with an address above the code
task automatic emit_hl(inout addr_t pc);
	emit(pc, 8'h26);
	emit(pc, rand_byte() | 8'h80);
endtask

// ------------------------------
// program generator
// ------------------------------
task automatic gen_program();
	addr_t pc;
	addr_t target;
	addr_t v;
	int skip;
	for (int a = 0; a < 65536; a++) begin
		v = a[15:0];
		mem[a] = v[15:8] ^ {v[6:0], v[7]} ^ 8'ha5;
	end
	pc = RESET_VECTOR;
	for (int n = 0; n < PROG_UNITS; n++) begin
		case ($urandom % 10)
			0: emit(pc, {2'b01, pick_reg(), pick_reg()}); // mov r,r
			1: begin
				emit_hl(pc);
				emit(pc, {2'b01, pick_reg(), REG_M});
			end
			2: begin
				emit_hl(pc);
				emit(pc, {2'b01, REG_M, pick_reg()});
			end
			3: begin
				emit(pc, {2'b00, pick_reg(), 3'b110});
				emit(pc, rand_byte());
			end
			4: begin
				emit_hl(pc);
				emit(pc, 8'h36); // mvi m
				emit(pc, rand_byte());
			end
			5: emit(pc, {2'b10, rand3(), pick_reg()});
			6: begin
				emit_hl(pc);
				emit(pc, {2'b10, rand3(), REG_M});
			end
			7: begin
				emit(pc, {2'b11, rand3(), 3'b110});
				emit(pc, rand_byte());
			end
			8: emit(pc, {2'b00, pick_reg(), 2'b10, rand3() > 3'd3}); // inr / dcr
			default: begin
				// forward jump over a few alu ops
				skip = 1 + $urandom % 4;
				target = pc + 16'd3 + skip[15:0];
				emit(pc, ($urandom % 4 == 0) ? 8'hc3 : {2'b11, rand3(), 3'b010});
				emit(pc, target[7:0]);
				emit(pc, target[15:8]);
				repeat (skip)
					emit(pc, {2'b10, rand3(), pick_reg()});
			end
		endcase
	end
	emit(pc, OPC_HLT);
	for (int a = 0; a < 65536; a++)
		model_mem[a] = mem[a];
endtask

// ------------------------------
// instruction level model
// ------------------------------
task automatic push_cycle(input cycle_e k, input addr_t a, input byte_t d);
	exp_kind.push_back(k);
	exp_addr.push_back(a);
	exp_data.push_back(d);
endtask

task automatic set_szp(input byte_t v);
	m_flags[FLAG_S] = v[7];
	m_flags[FLAG_Z] = (v == 8'h00);
	m_flags[FLAG_P] = ~^v; // even parity
endtask

task automatic model_alu(input logic [2:0] op, input byte_t b);
	logic [8:0] s;
	byte_t a;
	a = m_reg[REG_A];
	case (op)
		3'd0: s = {1'b0, a} + {1'b0, b}; // add
		3'd1: s = {1'b0, a} + {1'b0, b} + {8'd0, m_flags[FLAG_CY]};
		3'd3: s = {1'b0, a} - {1'b0, b} - {8'd0, m_flags[FLAG_CY]};
		3'd4: s = {1'b0, a & b};
		3'd5: s = {1'b0, a ^ b};
		3'd6: s = {1'b0, a | b};
		default: s = {1'b0, a} - {1'b0, b}; // sub and cmp
	endcase
	set_szp(s[7:0]);
	m_flags[FLAG_CY] = s[8];
	if (op != 3'd7)
		m_reg[REG_A] = s[7:0];
endtask

function automatic logic cond_true(input logic [2:0] cc);
	logic f;
	case (cc[2:1])
		2'b00: f = m_flags[FLAG_Z];
		2'b01: f = m_flags[FLAG_CY];
		2'b10: f = m_flags[FLAG_P];
		default: f = m_flags[FLAG_S];
	endcase
	return f == cc[0];
endfunction

task automatic run_model();
	addr_t pc;
	addr_t hl;
	byte_t op;
	byte_t v;
	byte_t lo;
	logic done;
	for (int i = 0; i < 8; i++)
		m_reg[i] = 8'h00;
	m_flags = 8'h02;
	pc = RESET_VECTOR;
	done = 1'b0;
	while (!done) begin
		op = model_mem[pc];
		push_cycle(OF, pc, 8'h00);
		pc = pc + 16'd1;
		hl = {m_reg[4], m_reg[5]};
		if (op == OPC_HLT) begin
			done = 1'b1;
		end else if (op[7:6] == 2'b01) begin
			if (op[5:3] == REG_M) begin
				push_cycle(MW, hl, m_reg[op[2:0]]);
				model_mem[hl] = m_reg[op[2:0]];
			end else if (op[2:0] == REG_M) begin
				push_cycle(MR, hl, 8'h00);
				m_reg[op[5:3]] = model_mem[hl];
			end else begin
				m_reg[op[5:3]] = m_reg[op[2:0]];
			end
		end else if (op[7:6] == 2'b10) begin
			if (op[2:0] == REG_M) begin
				push_cycle(MR, hl, 8'h00);
				model_alu(op[5:3], model_mem[hl]);
			end else begin
				model_alu(op[5:3], m_reg[op[2:0]]);
			end
		end else if (op[7:6] == 2'b00) begin
			if (op[2:0] == 3'b110) begin
				push_cycle(MR, pc, 8'h00); // immediate byte
				v = model_mem[pc];
				pc = pc + 16'd1;
				if (op[5:3] == REG_M) begin
					push_cycle(MW, hl, v);
					model_mem[hl] = v;
				end else begin
					m_reg[op[5:3]] = v;
				end
			end else begin
				v = op[0] ? m_reg[op[5:3]] - 8'd1 : m_reg[op[5:3]] + 8'd1;
				m_reg[op[5:3]] = v;
				set_szp(v); // carry untouched
			end
		end else if (op[2:0] == 3'b110) begin
			push_cycle(MR, pc, 8'h00);
			model_alu(op[5:3], model_mem[pc]);
			pc = pc + 16'd1;
		end else begin
			// jmp and jcc read both address bytes
			push_cycle(MR, pc, 8'h00);
			push_cycle(MR, pc + 16'd1, 8'h00);
			lo = model_mem[pc];
			v = model_mem[pc + 16'd1];
			pc = pc + 16'd2;
			if (op == 8'hc3 || cond_true(op[5:3]))
				pc = {v, lo};
		end
	end
endtask

`endif

// File: dv/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import i8085_pkg::*; ();

	logic clk;
	logic rst;
	logic i_ready;
	byte_t i_data;
	addr_t o_addr;
	byte_t o_data;
	logic o_ale;
	logic o_rd_n;
	logic o_wr_n;
	logic o_s1;
	logic o_s0;
	logic o_halt;

	int cyc_idx; // next expected bus cycle
	int wait_left;
	int cur_waits;
	int strobe_cnt;
	int wrong_cnt;
	cycle_e cur_kind;
	addr_t cur_addr;
	logic in_cycle;
	int cycle_count;
	int timeout_limit;

	`include "cpu_model.svh"

	cpu_top dut (
		.clk     (clk),
		.rst     (rst),
		.i_ready (i_ready),
		.i_data  (i_data),
		.o_addr  (o_addr),
		.o_data  (o_data),
		.o_ale   (o_ale),
		.o_rd_n  (o_rd_n),
		.o_wr_n  (o_wr_n),
		.o_s1    (o_s1),
		.o_s0    (o_s0),
		.o_halt  (o_halt)
	);

	always #20 clk = ~clk;

	// ------------------------------
	// checks
	// ------------------------------
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_cycle(input string name, input cycle_e exp, input cycle_e act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s: expected %s, actual %s", name, exp.name(),
				act.name()));
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_data(input string name, input byte_t exp, input byte_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	// ------------------------------
	// bus cycle tracking
	// ------------------------------
	task automatic open_cycle();
		string name;
		name = $sformatf("bus cycle %0d", cyc_idx);
		if (cyc_idx >= exp_kind.size()) begin
			fail_run("the core started more bus cycles than the program needs");
		end else begin
			check_cycle(name, exp_kind[cyc_idx], cycle_e'({o_s1, o_s0}));
			check_addr(name, exp_addr[cyc_idx], o_addr);
			cur_kind = exp_kind[cyc_idx];
			cur_addr = o_addr;
			wait_left = $urandom % 4;
			cur_waits = wait_left;
			strobe_cnt = 0;
			wrong_cnt = 0;
			in_cycle = 1'b1;
		end
	endtask

	task automatic track_cycle();
		string name;
		name = $sformatf("bus cycle %0d", cyc_idx);
		if (cur_kind == MW) begin
			if (!o_wr_n) begin
				strobe_cnt++;
				check_addr(name, cur_addr, o_addr);
				check_data(name, exp_data[cyc_idx], o_data);
				mem[cur_addr] = o_data;
			end
			if (!o_rd_n)
				wrong_cnt++;
		end else begin
			if (!o_rd_n) begin
				strobe_cnt++;
				check_addr(name, cur_addr, o_addr); // held through tw
			end
			if (!o_wr_n)
				wrong_cnt++;
		end
	endtask

	task automatic close_cycle();
		if (wrong_cnt != 0)
			fail_run($sformatf("bus cycle %0d asserted the wrong strobe", cyc_idx));
		else if (strobe_cnt != cur_waits + 2)
			fail_run($sformatf("bus cycle %0d held its strobe for %0d states with %0d waits",
				cyc_idx, strobe_cnt, cur_waits));
		else begin
			cyc_idx++;
			in_cycle = 1'b0;
		end
	endtask

	always @(negedge clk) begin
		if (!rst && !o_halt) begin
			if (o_ale) begin
				if (in_cycle)
					close_cycle();
				open_cycle();
			end else if (in_cycle) begin
				track_cycle();
			end else if (!o_rd_n || !o_wr_n) begin
				fail_run("a bus strobe was active before the first opcode fetch");
			end
		end else if (!rst && !in_cycle && cyc_idx == 0) begin
			fail_run("halt was active before the first opcode fetch");
		end
	end

	// memory responder, data and ready for the running cycle
	always @(posedge clk) begin
		if (wait_left > 0) begin
			i_ready <= 1'b0;
			wait_left = wait_left - 1;
		end else begin
			i_ready <= 1'b1;
		end
		i_data <= mem[cur_addr];
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit)
			fail_run($sformatf("timeout after %0d cycles, the core never halted", cycle_count));
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int unsigned seed;
		seed = 32'hc484;
		void'($urandom(seed));
		clk = 1'b0;
		rst = 1'b1;
		i_ready = 1'b0;
		i_data = 8'h00;
		cyc_idx = 0;
		wait_left = 0;
		cur_waits = 0;
		strobe_cnt = 0;
		wrong_cnt = 0;
		cur_kind = OF;
		cur_addr = RESET_VECTOR;
		in_cycle = 1'b0;
		cycle_count = 0;
		timeout_limit = 0;
		gen_program();
		run_model();
		timeout_limit = 6 * exp_kind.size() + 3 * exp_kind.size() + 100; // 3 waits max
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		while (!o_halt)
			@(negedge clk);
		if (in_cycle)
			close_cycle();
		check_cycle("halt status", HALT, cycle_e'({o_s1, o_s0}));
		repeat (50) begin
			@(negedge clk);
			if (o_ale || !o_halt || !o_rd_n || !o_wr_n)
				fail_run("the bus became active again after halt");
		end
		if (cyc_idx == exp_kind.size()) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			fail_run($sformatf("the core halted after %0d of %0d bus cycles", cyc_idx,
				exp_kind.size()));
		end
	end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import i8085_pkg::*; (
	input wire clk,
	input wire rst,
	input wire i_ready,
	input wire byte_t i_data,
	output addr_t o_addr,
	output byte_t o_data,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_s1,
	output logic o_s0,
	output logic o_halt
);

	mcycle_t mcycle;
	cycle_e next_kind;
	addr_src_e addr_src;
	op_class_e op_class;
	alu_op_e alu_op;
	logic [2:0] dst;
	logic [2:0] src;
	logic [2:0] cond;
	logic is_halt;
	logic fetch_done;
	logic read_done;
	logic exec_done;

	// ------------------------------
	// control
	// ------------------------------
	bus_sequencer u_seq (
		.clk          (clk),
		.rst          (rst),
		.i_ready      (i_ready),
		.i_next_kind  (next_kind),
		.i_is_halt    (is_halt),
		.o_mcycle     (mcycle),
		.o_ale        (o_ale),
		.o_rd_n       (o_rd_n),
		.o_wr_n       (o_wr_n),
		.o_s1         (o_s1),
		.o_s0         (o_s0),
		.o_halt       (o_halt),
		.o_fetch_done (fetch_done),
		.o_read_done  (read_done),
		.o_exec_done  (exec_done)
	);

	instr_decode u_dec (
		.clk          (clk),
		.rst          (rst),
		.i_data       (i_data),
		.i_fetch_done (fetch_done),
		.i_mcycle     (mcycle),
		.o_class      (op_class),
		.o_alu_op     (alu_op),
		.o_dst        (dst),
		.o_src        (src),
		.o_cond       (cond),
		.o_next_kind  (next_kind),
		.o_addr_src   (addr_src),
		.o_is_halt    (is_halt)
	);

	// ------------------------------
	// datapath
	// ------------------------------
	reg_file u_regs (
		.clk          (clk),
		.rst          (rst),
		.i_data       (i_data),
		.i_fetch_done (fetch_done),
		.i_read_done  (read_done),
		.i_exec_done  (exec_done),
		.i_class      (op_class),
		.i_alu_op     (alu_op),
		.i_dst        (dst),
		.i_src        (src),
		.i_cond       (cond),
		.i_addr_src   (addr_src),
		.o_addr       (o_addr),
		.o_data       (o_data)
	);

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import i8085_pkg::*; (
	input wire clk,
	input wire rst,
	input wire byte_t i_data,
	input wire i_fetch_done,
	input wire i_read_done,
	input wire i_exec_done,
	input wire op_class_e i_class,
	input wire alu_op_e i_alu_op,
	input wire [2:0] i_dst,
	input wire [2:0] i_src,
	input wire [2:0] i_cond,
	input wire addr_src_e i_addr_src,
	output addr_t o_addr,
	output byte_t o_data
);

	byte_t regs [0:5]; // b c d e h l
	byte_t acc;
	byte_t flags;
	addr_t pc;
	byte_t tmp; // mvi m operand
	byte_t jmp_lo;
	byte_t src_val;
	byte_t dst_val;
	byte_t alu_b;
	byte_t alu_res;
	byte_t alu_flags;
	byte_t wr_val;
	logic wr_en;
	logic cond_bit;
	logic take_jump;

	// register field read, m reads the temp byte
	function automatic byte_t read_reg(input logic [2:0] code);
		if (code == REG_A)
			return acc;
		else if (code == REG_M)
			return tmp;
		else
			return regs[code];
	endfunction

	assign src_val = read_reg(i_src);
	assign dst_val = read_reg(i_dst);

	// ------------------------------
	// bus side
	// ------------------------------
	assign o_addr = (i_addr_src == HL) ? {regs[4], regs[5]} : pc;
	assign o_data = (i_class == MVI_M) ? tmp : src_val;

	// ------------------------------
	// alu and jump test
	// ------------------------------
	always_comb begin
		case (i_class)
			ALU_M, ALU_I: alu_b = i_data; // operand arrives with exec_done
			INR_DCR: alu_b = dst_val;
			default: alu_b = src_val;
		endcase
	end

	alu u_alu (
		.i_op     (i_alu_op),
		.i_a      (acc),
		.i_b      (alu_b),
		.i_cy     (flags[FLAG_CY]),
		.i_incdec (i_class == INR_DCR),
		.i_dec    (i_alu_op == SUB),
		.o_result (alu_res),
		.o_flags  (alu_flags)
	);

	always_comb begin
		case (i_cond[2:1])
			2'b00: cond_bit = flags[FLAG_Z];
			2'b01: cond_bit = flags[FLAG_CY];
			2'b10: cond_bit = flags[FLAG_P];
			default: cond_bit = flags[FLAG_S];
		endcase
	end

	assign take_jump = (i_class == JMP) || (i_class == JCC && cond_bit == i_cond[0]);

	// destination write for mov / mvi / inr / dcr
	always_comb begin
		wr_en = 1'b0;
		wr_val = src_val;
		case (i_class)
			MOV_RR: wr_en = 1'b1;
			MOV_RM, MVI_R: begin
				wr_en = 1'b1;
				wr_val = i_data;
			end
			INR_DCR: begin
				wr_en = 1'b1;
				wr_val = alu_res;
			end
			default: wr_en = 1'b0;
		endcase
	end

	// ------------------------------
	// architectural state
	// ------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 6; i++)
				regs[i] <= 8'h00;
			acc <= 8'h00;
			flags <= 8'h02;
			pc <= RESET_VECTOR;
		end else begin
			if (i_exec_done && wr_en) begin
				if (i_dst == REG_A)
					acc <= wr_val;
				else if (i_dst != REG_M)
					regs[i_dst] <= wr_val;
			end
			if (i_exec_done && (i_class == ALU_R || i_class == ALU_M || i_class == ALU_I))
				acc <= alu_res; // cmp passes acc through
			if (i_exec_done && (i_class inside {ALU_R, ALU_M, ALU_I, INR_DCR}))
				flags <= alu_flags;
			if (i_exec_done && take_jump)
				pc <= {i_data, jmp_lo};
			else if (i_fetch_done || (i_read_done && i_addr_src == PC))
				pc <= pc + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_read_done) begin
			if (i_class == JMP || i_class == JCC)
				jmp_lo <= i_data;
			else
				tmp <= i_data;
		end
	end

endmodule

`default_nettype wire

// File: hw/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode import i8085_pkg::*; (
	input wire clk,
	input wire rst,
	input wire byte_t i_data,
	input wire i_fetch_done,
	input wire mcycle_t i_mcycle,
	output op_class_e o_class,
	output alu_op_e o_alu_op,
	output logic [2:0] o_dst,
	output logic [2:0] o_src,
	output logic [2:0] o_cond,
	output cycle_e o_next_kind,
	output addr_src_e o_addr_src,
	output logic o_is_halt
);

	byte_t ir;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ir <= 8'h00; // nop
		else if (i_fetch_done)
			ir <= i_data;
	end

	assign o_dst = ir[5:3];
	assign o_src = ir[2:0];
	assign o_cond = ir[5:3];
	assign o_is_halt = (o_class == HLT);

	// ------------------------------
	// opcode class
	// ------------------------------
	always_comb begin
		o_class = MOV_RR; // unknown opcodes act as a register move
		o_alu_op = alu_op_e'(ir[5:3]);
		if (ir == OPC_HLT) begin
			o_class = HLT;
		end else begin
			case (ir[7:6])
				2'b01: begin
					if (ir[5:3] == REG_M)
						o_class = MOV_MR;
					else if (ir[2:0] == REG_M)
						o_class = MOV_RM;
				end
				2'b00: begin
					if (ir[2:0] == 3'b110) begin
						o_class = (ir[5:3] == REG_M) ? MVI_M : MVI_R;
					end else if (ir[2:1] == 2'b10) begin
						o_class = INR_DCR;
						o_alu_op = ir[0] ? SUB : ADD; // dcr / inr
					end
				end
				2'b10: o_class = (ir[2:0] == REG_M) ? ALU_M : ALU_R;
				default: begin
					if (ir[2:0] == 3'b110)
						o_class = ALU_I;
					else if (ir == 8'hc3)
						o_class = JMP;
					else if (ir[2:0] == 3'b010)
						o_class = JCC;
				end
			endcase
		end
	end

	// ------------------------------
	// cycle plan
	// ------------------------------
	// kind of the following cycle, source of the current one
	always_comb begin
		o_next_kind = OF;
		o_addr_src = PC; // opcode fetch always from pc
		case (i_mcycle)
			2'd0: begin
				case (o_class)
					MOV_RM, ALU_M, MVI_R, MVI_M, ALU_I, JMP, JCC: o_next_kind = MR;
					MOV_MR: o_next_kind = MW;
					HLT: o_next_kind = HALT;
					default: o_next_kind = OF;
				endcase
			end
			2'd1: begin
				if (o_class == MOV_RM || o_class == MOV_MR || o_class == ALU_M)
					o_addr_src = HL;
				if (o_class == MVI_M)
					o_next_kind = MW;
				else if (o_class == JMP || o_class == JCC)
					o_next_kind = MR; // high address byte
			end
			2'd2: begin
				if (o_class == MVI_M)
					o_addr_src = HL;
			end
			default: o_next_kind = OF;
		endcase
	end

	a_hlt_single: assert property (@(posedge clk) disable iff (rst)
		(i_mcycle != 2'd0) |-> (o_class != HLT));

endmodule

`default_nettype wire

// File: hw/bus_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer import i8085_pkg::*; (
	input wire clk,
	input wire rst,
	input wire i_ready,
	input wire cycle_e i_next_kind,
	input wire i_is_halt,
	output mcycle_t o_mcycle,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_s1,
	output logic o_s0,
	output logic o_halt,
	output logic o_fetch_done,
	output logic o_read_done,
	output logic o_exec_done
);

	tstate_e state;
	tstate_e state_n;
	cycle_e kind; // kind of the running cycle
	cycle_e kind_n;
	mcycle_t mcycle_n;
	logic last_cycle;
	logic bus_active;

	// decoder says the instruction is over after this cycle
	assign last_cycle = (i_next_kind == OF);

	// ------------------------------
	// next state
	// ------------------------------
	always_comb begin
		state_n = state;
		kind_n = kind;
		mcycle_n = o_mcycle;
		case (state)
			TR: begin
				state_n = T1;
				kind_n = OF;
				mcycle_n = '0;
			end
			T1: state_n = T2;
			T2, TW: begin
				if (i_ready) // sampled at end of t2 / tw
					state_n = T3;
				else
					state_n = TW;
			end
			T3, T4: begin
				if (state == T3 && kind == OF) begin
					state_n = T4; // opcode lands in ir at this edge
				end else if (state == T4 && i_is_halt) begin
					state_n = TT;
					kind_n = i_next_kind;
				end else begin
					state_n = T1;
					kind_n = i_next_kind;
					mcycle_n = last_cycle ? mcycle_t'(0) : mcycle_t'(o_mcycle + 2'd1);
				end
			end
			TT: state_n = TT; // only reset leaves
			default: state_n = TR;
		endcase
	end

	assign bus_active = (state_n == T2) || (state_n == TW) || (state_n == T3);

	// ------------------------------
	// state and registered bus outputs
	// ------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= TR;
			kind <= HALT;
			o_mcycle <= '0;
			o_ale <= 1'b0;
			o_rd_n <= 1'b1;
			o_wr_n <= 1'b1;
			o_s1 <= 1'b0;
			o_s0 <= 1'b0;
			o_halt <= 1'b0;
		end else begin
			state <= state_n;
			kind <= kind_n;
			o_mcycle <= mcycle_n;
			o_ale <= (state_n == T1);
			o_rd_n <= ~(bus_active && (kind_n == OF || kind_n == MR));
			o_wr_n <= ~(bus_active && kind_n == MW);
			{o_s1, o_s0} <= kind_n;
			o_halt <= (state_n == TT);
		end
	end

	// ------------------------------
	// datapath strobes
	// ------------------------------
	assign o_fetch_done = (state == T3) && (kind == OF);
	assign o_read_done = (state == T3) && (kind == MR);
	assign o_exec_done = ((state == T4) && !i_is_halt && last_cycle) ||
		((state == T3) && (kind != OF) && last_cycle);

	// read and write strobes are exclusive
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
		!(!o_rd_n && !o_wr_n));

	// ale is one state wide with strobes idle
	a_ale_t1: assert property (@(posedge clk) disable iff (rst)
		o_ale |-> (o_rd_n && o_wr_n) ##1 !o_ale);

	a_mcycle_range: assert property (@(posedge clk) disable iff (rst)
		o_mcycle < MAX_MCYCLES);

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import i8085_pkg::*; (
	input wire alu_op_e i_op,
	input wire byte_t i_a,
	input wire byte_t i_b,
	input wire i_cy,
	input wire i_incdec,
	input wire i_dec,
	output byte_t o_result,
	output byte_t o_flags
);

	logic [8:0] sum; // bit 8 is carry / borrow
	byte_t res;
	logic cy;

	// ------------------------------
	// arithmetic and logic
	// ------------------------------
	always_comb begin
		sum = 9'd0;
		if (i_incdec) begin
			res = i_dec ? i_b - 8'd1 : i_b + 8'd1;
			cy = i_cy; // inr / dcr keep carry
		end else begin
			case (i_op)
				ADD: sum = {1'b0, i_a} + {1'b0, i_b};
				ADC: sum = {1'b0, i_a} + {1'b0, i_b} + {8'd0, i_cy};
				SUB, CMP: sum = {1'b0, i_a} - {1'b0, i_b};
				SBB: sum = {1'b0, i_a} - {1'b0, i_b} - {8'd0, i_cy};
				ANA: sum = {1'b0, i_a & i_b}; // logic ops clear carry
				XRA: sum = {1'b0, i_a ^ i_b};
				ORA: sum = {1'b0, i_a | i_b};
				default: sum = {1'b0, i_a};
			endcase
			res = sum[7:0];
			cy = sum[8];
		end
	end

	// compare sets flags only, accumulator comes back unchanged
	assign o_result = (!i_incdec && i_op == CMP) ? i_a : res;

	// ------------------------------
	// flags
	// ------------------------------
	always_comb begin
		o_flags = 8'h02; // bit 1 reads as one
		o_flags[FLAG_S] = res[7];
		o_flags[FLAG_Z] = (res == 8'h00);
		o_flags[FLAG_P] = ~^res; // even parity
		o_flags[FLAG_CY] = cy;
	end

endmodule

`default_nettype wire

// File: hw/i8085_pkg.sv
`default_nettype none

package i8085_pkg;

	// ------------------------------
	// basic types
	// ------------------------------
	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [1:0] mcycle_t; // cycle index inside one instruction

	// ------------------------------
	// bus sequencing
	// ------------------------------
	typedef enum logic [2:0] {
		TR, // reset
		T1, // address out, ale
		T2,
		TW, // wait for ready
		T3, // data sampled at its end
		T4, // opcode fetch only
		TT  // halted
	} tstate_e;

	// value doubles as the {s1,s0} status pair
	typedef enum logic [1:0] {
		HALT = 2'b00,
		MW   = 2'b01,
		MR   = 2'b10,
		OF   = 2'b11
	} cycle_e;

	typedef enum logic [0:0] {
		PC,
		HL
	} addr_src_e;

	// ------------------------------
	// instruction set
	// ------------------------------
	typedef enum logic [3:0] {
		MOV_RR, MOV_RM, MOV_MR,
		MVI_R, MVI_M,
		ALU_R, ALU_M, ALU_I,
		INR_DCR,
		JMP, JCC,
		HLT
	} op_class_e;

	// same as opcode bits 5:3
	typedef enum logic [2:0] {
		ADD, ADC, SUB, SBB, ANA, XRA, ORA, CMP
	} alu_op_e;

	localparam addr_t RESET_VECTOR = 16'h0000;
	localparam byte_t OPC_HLT = 8'h76;
	localparam logic [2:0] REG_M = 3'd6; // memory at hl
	localparam logic [2:0] REG_A = 3'd7;

	// flag byte layout
	localparam int FLAG_S = 7;
	localparam int FLAG_Z = 6;
	localparam int FLAG_P = 2;
	localparam int FLAG_CY = 0;

	localparam int MAX_MCYCLES = 3; // jumps: fetch plus two address bytes

endpackage

`default_nettype wire
